/* hdl/bridge_defines.svh */
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// datapath widths
`define BRIDGE_ADDR_W       32
`define BRIDGE_DATA_W       32
`define BRIDGE_BEATS        8
`define BRIDGE_BLOCK_W      256
`define BRIDGE_OFFSET_W     5
`define BRIDGE_BEAT_CNT_W   3

// AXI3 field widths
`define BRIDGE_ID_W         4
`define BRIDGE_LEN_W        4
`define BRIDGE_SIZE_W       3
`define BRIDGE_BURST_W      2
`define BRIDGE_LOCK_W       2
`define BRIDGE_CACHE_W      4
`define BRIDGE_PROT_W       3
`define BRIDGE_RESP_W       2
`define BRIDGE_STRB_W       4

// AXI field codes
`define BRIDGE_LEN_BLOCK    4'd7
`define BRIDGE_SIZE_WORD    3'b010
`define BRIDGE_BURST_INCR   2'b01
`define BRIDGE_CACHE_ATTR   4'b0011
`define BRIDGE_PROT_DATA    3'b000
`define BRIDGE_LOCK_NORMAL  2'b00
`define BRIDGE_READ_ID      4'd0
`define BRIDGE_WRITE_ID     4'd1
`define BRIDGE_STRB_ALL     4'b1111

`endif

/* hdl/bridge_pkg.sv */
`include "bridge_defines.svh"

package bridge_pkg;

    // request code from the cache
    typedef enum logic [1:0] {
        REQ_NONE        = 2'd0,
        REQ_LOAD_BLOCK  = 2'd1,
        REQ_STORE_BLOCK = 2'd2
    } req_e;

    // byte address
    typedef logic [`BRIDGE_ADDR_W-1:0] addr_t;

    // one AXI beat
    typedef logic [`BRIDGE_DATA_W-1:0] word_t;

    // whole cache block, word 0 in the low bits
    typedef logic [`BRIDGE_BLOCK_W-1:0] block_t;

endpackage

/* hdl/req_ctrl.sv */
`timescale 1ns/100ps

`include "bridge_defines.svh"

module req_ctrl (
    input  logic               clk,
    input  logic               rstn,
    input  bridge_pkg::req_e   req,
    input  bridge_pkg::addr_t  addr,
    input  bridge_pkg::block_t wblock,
    input  logic               rd_done,
    input  bridge_pkg::block_t rd_block,
    input  logic               wr_done,
    output logic               rd_start,
    output logic               wr_start,
    output bridge_pkg::addr_t  job_addr,
    output bridge_pkg::block_t job_block,
    output bridge_pkg::block_t rblock,
    output logic               task_finish
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LAUNCH,
        ST_BUSY
    } state_e;

    state_e state;
    logic   op_write;
    logic   accept;

    // requests arriving while busy are dropped
    assign accept = (state == ST_IDLE) &&
                    ((req == bridge_pkg::REQ_LOAD_BLOCK) ||
                     (req == bridge_pkg::REQ_STORE_BLOCK));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= ST_IDLE;
            op_write    <= 1'b0;
            rd_start    <= 1'b0;
            wr_start    <= 1'b0;
            task_finish <= 1'b0;
        end else begin
            rd_start    <= 1'b0;
            wr_start    <= 1'b0;
            task_finish <= rd_done | wr_done;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        op_write <= (req == bridge_pkg::REQ_STORE_BLOCK);
                        state    <= ST_LAUNCH;
                    end
                end
                ST_LAUNCH: begin
                    rd_start <= ~op_write;
                    wr_start <= op_write;
                    state    <= ST_BUSY;
                end
                default: begin
                    if (rd_done || wr_done) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // job payload, address aligned to the block
    always_ff @(posedge clk) begin
        if (accept) begin
            job_addr  <= {addr[`BRIDGE_ADDR_W-1:`BRIDGE_OFFSET_W], {`BRIDGE_OFFSET_W{1'b0}}};
            job_block <= wblock;
        end
        if (rd_done) begin
            rblock <= rd_block;
        end
    end

endmodule

/* hdl/rd_burst.sv */
`timescale 1ns/100ps

`include "bridge_defines.svh"

module rd_burst (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        rd_start,
    input  bridge_pkg::addr_t           job_addr,
    input  logic                        arready,
    input  bridge_pkg::word_t           rdata,
    input  logic                        rvalid,
    input  logic                        rlast,
    output bridge_pkg::addr_t           araddr,
    output logic [`BRIDGE_LEN_W-1:0]    arlen,
    output logic [`BRIDGE_SIZE_W-1:0]   arsize,
    output logic [`BRIDGE_BURST_W-1:0]  arburst,
    output logic                        arvalid,
    output logic                        rready,
    output bridge_pkg::block_t          rd_block,
    output logic                        rd_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA
    } state_e;

    state_e                         state;
    logic [`BRIDGE_BEAT_CNT_W-1:0]  beat_cnt;
    logic                           beat_take;
    logic                           beat_final;

    assign beat_take  = (state == ST_DATA) && rvalid && rready;
    // eighth beat, or an early rlast from the slave
    assign beat_final = rlast || (beat_cnt == `BRIDGE_BEAT_CNT_W'(`BRIDGE_BEATS - 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= ST_IDLE;
            beat_cnt <= '0;
            arvalid  <= 1'b0;
            rready   <= 1'b0;
            rd_done  <= 1'b0;
        end else begin
            rd_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (rd_start) begin
                        arvalid <= 1'b1;
                        state   <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (arready) begin
                        arvalid  <= 1'b0;
                        rready   <= 1'b1;
                        beat_cnt <= '0;
                        state    <= ST_DATA;
                    end
                end
                default: begin
                    if (beat_take) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_final) begin
                            rready  <= 1'b0;
                            rd_done <= 1'b1;
                            state   <= ST_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    // burst fields held stable while arvalid is up
    always_ff @(posedge clk) begin
        if (rd_start && state == ST_IDLE) begin
            araddr  <= job_addr;
            arlen   <= `BRIDGE_LEN_BLOCK;
            arsize  <= `BRIDGE_SIZE_WORD;
            arburst <= `BRIDGE_BURST_INCR;
        end
        if (beat_take) begin
            rd_block[`BRIDGE_DATA_W*beat_cnt +: `BRIDGE_DATA_W] <= rdata;
        end
    end

endmodule

/* hdl/wr_burst.sv */
`timescale 1ns/100ps

`include "bridge_defines.svh"

module wr_burst (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        wr_start,
    input  bridge_pkg::addr_t           job_addr,
    input  bridge_pkg::block_t          job_block,
    input  logic                        awready,
    input  logic                        wready,
    input  logic                        bvalid,
    output bridge_pkg::addr_t           awaddr,
    output logic [`BRIDGE_LEN_W-1:0]    awlen,
    output logic [`BRIDGE_SIZE_W-1:0]   awsize,
    output logic [`BRIDGE_BURST_W-1:0]  awburst,
    output logic                        awvalid,
    output bridge_pkg::word_t           wdata,
    output logic [`BRIDGE_STRB_W-1:0]   wstrb,
    output logic                        wlast,
    output logic                        wvalid,
    output logic                        bready,
    output logic                        wr_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_RESP
    } state_e;

    state_e                         state;
    logic [`BRIDGE_BEAT_CNT_W-1:0]  beat_cnt;
    logic [`BRIDGE_BEAT_CNT_W-1:0]  next_cnt;
    logic                           aw_take;
    logic                           w_take;

    assign next_cnt = beat_cnt + 1'b1;
    assign aw_take  = (state == ST_ADDR) && awready;
    assign w_take   = (state == ST_DATA) && wvalid && wready;

    // whole words only
    assign wstrb = `BRIDGE_STRB_ALL;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= ST_IDLE;
            beat_cnt <= '0;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            wlast    <= 1'b0;
            bready   <= 1'b0;
            wr_done  <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (wr_start) begin
                        awvalid <= 1'b1;
                        state   <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (aw_take) begin
                        awvalid  <= 1'b0;
                        wvalid   <= 1'b1;
                        wlast    <= 1'b0;
                        beat_cnt <= '0;
                        state    <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (w_take) begin
                        if (wlast) begin
                            wvalid <= 1'b0;
                            wlast  <= 1'b0;
                            bready <= 1'b1;
                            state  <= ST_RESP;
                        end else begin
                            beat_cnt <= next_cnt;
                            wlast    <= (next_cnt == `BRIDGE_BEAT_CNT_W'(`BRIDGE_BEATS - 1));
                        end
                    end
                end
                default: begin
                    if (bvalid) begin
                        bready  <= 1'b0;
                        wr_done <= 1'b1;
                        state   <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // address fields and the word on W
    always_ff @(posedge clk) begin
        if (wr_start && state == ST_IDLE) begin
            awaddr  <= job_addr;
            awlen   <= `BRIDGE_LEN_BLOCK;
            awsize  <= `BRIDGE_SIZE_WORD;
            awburst <= `BRIDGE_BURST_INCR;
        end
        if (aw_take) begin
            wdata <= job_block[`BRIDGE_DATA_W-1:0];
        end else if (w_take && !wlast) begin
            wdata <= job_block[`BRIDGE_DATA_W*next_cnt +: `BRIDGE_DATA_W];
        end
    end

endmodule

/* hdl/axi_block_bridge.sv */
`timescale 1ns/100ps

`include "bridge_defines.svh"

module axi_block_bridge (
    input  logic                        clk,
    input  logic                        rstn,

    // cache side
    input  bridge_pkg::req_e            req,
    input  bridge_pkg::addr_t           addr,
    input  bridge_pkg::block_t          wblock,
    output bridge_pkg::block_t          rblock,
    output logic                        task_finish,

    // read address
    output logic [`BRIDGE_ID_W-1:0]     arid,
    output bridge_pkg::addr_t           araddr,
    output logic [`BRIDGE_LEN_W-1:0]    arlen,
    output logic [`BRIDGE_SIZE_W-1:0]   arsize,
    output logic [`BRIDGE_BURST_W-1:0]  arburst,
    output logic [`BRIDGE_LOCK_W-1:0]   arlock,
    output logic [`BRIDGE_CACHE_W-1:0]  arcache,
    output logic [`BRIDGE_PROT_W-1:0]   arprot,
    output logic                        arvalid,
    input  logic                        arready,

    // write address
    output logic [`BRIDGE_ID_W-1:0]     awid,
    output bridge_pkg::addr_t           awaddr,
    output logic [`BRIDGE_LEN_W-1:0]    awlen,
    output logic [`BRIDGE_SIZE_W-1:0]   awsize,
    output logic [`BRIDGE_BURST_W-1:0]  awburst,
    output logic [`BRIDGE_LOCK_W-1:0]   awlock,
    output logic [`BRIDGE_CACHE_W-1:0]  awcache,
    output logic [`BRIDGE_PROT_W-1:0]   awprot,
    output logic                        awvalid,
    input  logic                        awready,

    // read data, id and resp not checked
    input  logic [`BRIDGE_ID_W-1:0]     rid,
    input  bridge_pkg::word_t           rdata,
    input  logic [`BRIDGE_RESP_W-1:0]   rresp,
    input  logic                        rlast,
    input  logic                        rvalid,
    output logic                        rready,

    // write data
    output logic [`BRIDGE_ID_W-1:0]     wid,
    output bridge_pkg::word_t           wdata,
    output logic [`BRIDGE_STRB_W-1:0]   wstrb,
    output logic                        wlast,
    output logic                        wvalid,
    input  logic                        wready,

    // write response, id and resp not checked
    input  logic [`BRIDGE_ID_W-1:0]     bid,
    input  logic [`BRIDGE_RESP_W-1:0]   bresp,
    output logic                        bready,
    input  logic                        bvalid
);

    logic               rd_start;
    logic               wr_start;
    logic               rd_done;
    logic               wr_done;
    bridge_pkg::addr_t  job_addr;
    bridge_pkg::block_t job_block;
    bridge_pkg::block_t rd_block;

    // fixed attributes, same for every burst
    assign arid    = `BRIDGE_READ_ID;
    assign arlock  = `BRIDGE_LOCK_NORMAL;
    assign arcache = `BRIDGE_CACHE_ATTR;
    assign arprot  = `BRIDGE_PROT_DATA;
    assign awid    = `BRIDGE_WRITE_ID;
    assign awlock  = `BRIDGE_LOCK_NORMAL;
    assign awcache = `BRIDGE_CACHE_ATTR;
    assign awprot  = `BRIDGE_PROT_DATA;
    assign wid     = `BRIDGE_WRITE_ID;

    req_ctrl req_ctrl_i (
        .clk         (clk),
        .rstn        (rstn),
        .req         (req),
        .addr        (addr),
        .wblock      (wblock),
        .rd_done     (rd_done),
        .rd_block    (rd_block),
        .wr_done     (wr_done),
        .rd_start    (rd_start),
        .wr_start    (wr_start),
        .job_addr    (job_addr),
        .job_block   (job_block),
        .rblock      (rblock),
        .task_finish (task_finish)
    );

    rd_burst rd_burst_i (
        .clk      (clk),
        .rstn     (rstn),
        .rd_start (rd_start),
        .job_addr (job_addr),
        .arready  (arready),
        .rdata    (rdata),
        .rvalid   (rvalid),
        .rlast    (rlast),
        .araddr   (araddr),
        .arlen    (arlen),
        .arsize   (arsize),
        .arburst  (arburst),
        .arvalid  (arvalid),
        .rready   (rready),
        .rd_block (rd_block),
        .rd_done  (rd_done)
    );

    wr_burst wr_burst_i (
        .clk       (clk),
        .rstn      (rstn),
        .wr_start  (wr_start),
        .job_addr  (job_addr),
        .job_block (job_block),
        .awready   (awready),
        .wready    (wready),
        .bvalid    (bvalid),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awsize    (awsize),
        .awburst   (awburst),
        .awvalid   (awvalid),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wlast     (wlast),
        .wvalid    (wvalid),
        .bready    (bready),
        .wr_done   (wr_done)
    );

endmodule

/* verification/axi_mem_slave.sv */
`timescale 1ns/100ps

module axi_mem_slave (
    input  logic        clk,
    input  logic        rstn,
    input  logic [31:0] araddr,
    input  logic [3:0]  arlen,
    input  logic [2:0]  arsize,
    input  logic [1:0]  arburst,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready,
    input  logic [31:0] awaddr,
    input  logic [3:0]  awlen,
    input  logic [2:0]  awsize,
    input  logic [1:0]  awburst,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wlast,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    input  logic        bready,
    output integer      ar_count,
    output integer      aw_count,
    output integer      fault_count
);

    // 64 words, eight blocks of eight
    logic [31:0] mem [0:63];
    logic [2:0]  rd_blk;
    logic [2:0]  wr_blk;
    logic [3:0]  r_beat;
    logic [3:0]  w_beat;
    logic        rd_active;
    logic        b_pending;
    integer      seed = 49481;
    integer      ar_n = 0;
    integer      aw_n = 0;
    integer      fault_n = 0;

    assign ar_count    = ar_n;
    assign aw_count    = aw_n;
    assign fault_count = fault_n;

    // one random bit for a stall decision
    function automatic logic coin();
        integer r;
        r = $random(seed);
        return r[0];
    endfunction

    task automatic report_fault(input string what);
        fault_n = fault_n + 1;
        $display("slave: %s at time %0t", what, $time);
    endtask

    always @(posedge clk) begin
        if (!rstn) begin
            arready   <= 1'b0;
            awready   <= 1'b0;
            wready    <= 1'b0;
            rvalid    <= 1'b0;
            rlast     <= 1'b0;
            rdata     <= 32'd0;
            bvalid    <= 1'b0;
            rd_active <= 1'b0;
            b_pending <= 1'b0;
            rd_blk    <= 3'd0;
            wr_blk    <= 3'd0;
            r_beat    <= 4'd0;
            w_beat    <= 4'd0;
            // fill pattern mixes every address bit
            for (int i = 0; i < 64; i++) begin
                mem[6'(i)] <= 32'h9e3779b9 * 32'(i + 1);
            end
        end else begin
            arready <= coin();
            awready <= coin();
            wready  <= coin();

            // eight-beat INCR bursts of whole words, block aligned
            if (arvalid && arready) begin
                ar_n = ar_n + 1;
                if (araddr[4:0] != 5'd0 || arlen != 4'd7 || arsize != 3'b010 ||
                    arburst != 2'b01) begin
                    report_fault("read burst with bad address, len, size or burst");
                end
                rd_active <= 1'b1;
                rd_blk    <= araddr[7:5];
                r_beat    <= 4'd0;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                rlast  <= 1'b0;
                r_beat <= r_beat + 4'd1;
                if (rlast) begin
                    rd_active <= 1'b0;
                end
            end else if (rd_active && !rvalid && coin()) begin
                rvalid <= 1'b1;
                rdata  <= mem[{rd_blk, r_beat[2:0]}];
                rlast  <= (r_beat == 4'd7);
            end

            if (awvalid && awready) begin
                aw_n = aw_n + 1;
                if (awaddr[4:0] != 5'd0 || awlen != 4'd7 || awsize != 3'b010 ||
                    awburst != 2'b01) begin
                    report_fault("write burst with bad address, len, size or burst");
                end
                wr_blk <= awaddr[7:5];
                w_beat <= 4'd0;
            end
            if (wvalid && wready) begin
                if (wstrb != 4'hf) begin
                    report_fault("write beat without a full strobe");
                end
                if (wlast != (w_beat == 4'd7)) begin
                    report_fault("wlast not on the eighth write beat");
                end
                mem[{wr_blk, w_beat[2:0]}] <= wdata;
                w_beat <= w_beat + 4'd1;
                if (wlast) begin
                    b_pending <= 1'b1;
                end
            end
            if (bvalid && bready) begin
                bvalid    <= 1'b0;
                b_pending <= 1'b0;
            end else if (b_pending && !bvalid && coin()) begin
                bvalid <= 1'b1;
            end
        end
    end

endmodule

/* verification/tb_axi_block_bridge.sv */
`timescale 1ns/100ps

module tb_axi_block_bridge;

    logic               clk;
    logic               rstn;
    bridge_pkg::req_e   req;
    bridge_pkg::addr_t  addr;
    bridge_pkg::block_t wblock;
    bridge_pkg::block_t rblock;
    logic               task_finish;

    logic [3:0]  arid;
    logic [31:0] araddr;
    logic [3:0]  arlen;
    logic [2:0]  arsize;
    logic [1:0]  arburst;
    logic [1:0]  arlock;
    logic [3:0]  arcache;
    logic [2:0]  arprot;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rlast;
    logic        rvalid;
    logic        rready;
    logic [3:0]  awid;
    logic [31:0] awaddr;
    logic [3:0]  awlen;
    logic [2:0]  awsize;
    logic [1:0]  awburst;
    logic [1:0]  awlock;
    logic [3:0]  awcache;
    logic [2:0]  awprot;
    logic        awvalid;
    logic        awready;
    logic [3:0]  wid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wlast;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;

    integer ar_count;
    integer aw_count;
    integer fault_count;
    integer seed = 49481;
    integer errors = 0;
    integer timeouts = 0;
    integer finish_count = 0;
    integer n_load = 0;
    integer n_store = 0;
    logic   timed_out = 1'b0;

    // reference memory laid out like the slave
    bridge_pkg::word_t ref_mem [0:63];

    axi_block_bridge dut_i (
        .clk(clk), .rstn(rstn), .req(req), .addr(addr), .wblock(wblock),
        .rblock(rblock), .task_finish(task_finish),
        .arid(arid), .araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
        .arlock(arlock), .arcache(arcache), .arprot(arprot), .arvalid(arvalid),
        .arready(arready),
        .awid(awid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize), .awburst(awburst),
        .awlock(awlock), .awcache(awcache), .awprot(awprot), .awvalid(awvalid),
        .awready(awready),
        .rid(4'd0), .rdata(rdata), .rresp(2'b00), .rlast(rlast), .rvalid(rvalid),
        .rready(rready), .wid(wid), .wdata(wdata), .wstrb(wstrb), .wlast(wlast),
        .wvalid(wvalid), .wready(wready), .bid(4'd1), .bresp(2'b00),
        .bready(bready), .bvalid(bvalid)
    );

    axi_mem_slave slave_i (
        .clk(clk), .rstn(rstn),
        .araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
        .arvalid(arvalid), .arready(arready), .rdata(rdata), .rlast(rlast),
        .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awlen(awlen), .awsize(awsize), .awburst(awburst),
        .awvalid(awvalid), .awready(awready), .wdata(wdata), .wstrb(wstrb),
        .wlast(wlast), .wvalid(wvalid), .wready(wready), .bvalid(bvalid),
        .bready(bready), .ar_count(ar_count), .aw_count(aw_count),
        .fault_count(fault_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        if (task_finish === 1'b1) begin
            finish_count = finish_count + 1;
        end
    end

    task automatic compare_value(input string name, input logic [255:0] got,
                                 input logic [255:0] exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("ERR time %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // fixed ids and attributes whenever an address or data beat is offered
    always @(negedge clk) begin
        if (arvalid === 1'b1) begin
            compare_value("arid", 256'(arid), 256'd0);
            compare_value("arlock", 256'(arlock), 256'd0);
            compare_value("arcache", 256'(arcache), 256'h3);
            compare_value("arprot", 256'(arprot), 256'd0);
        end
        if (awvalid === 1'b1) begin
            compare_value("awid", 256'(awid), 256'd1);
            compare_value("awlock", 256'(awlock), 256'd0);
            compare_value("awcache", 256'(awcache), 256'h3);
            compare_value("awprot", 256'(awprot), 256'd0);
        end
        if (wvalid === 1'b1) begin
            compare_value("wid", 256'(wid), 256'd1);
        end
    end

    // word 0 of the block in the low bits
    function automatic bridge_pkg::block_t expected_block(input logic [2:0] blk);
        bridge_pkg::block_t res;
        for (int w = 0; w < 8; w++) begin
            res[32*w +: 32] = ref_mem[{blk, 3'(w)}];
        end
        return res;
    endfunction

    function automatic bridge_pkg::block_t random_block();
        bridge_pkg::block_t res;
        for (int w = 0; w < 8; w++) begin
            res[32*w +: 32] = $random(seed);
        end
        return res;
    endfunction

    task automatic wait_finish(output logic seen);
        integer cycles;
        cycles = 0;
        @(negedge clk);
        while (task_finish !== 1'b1 && cycles < 1000) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        seen = (task_finish === 1'b1);
        if (!seen) begin
            timeouts = timeouts + 1;
            timed_out = 1'b1;
            $display("timeout: no task_finish within %0d cycles at time %0t", cycles, $time);
        end
    endtask

    task automatic run_request(input bridge_pkg::req_e kind, input bridge_pkg::addr_t a,
                               input bridge_pkg::block_t blk);
        integer r;
        logic   seen;
        @(posedge clk);
        req    <= kind;
        addr   <= a;
        wblock <= blk;
        if (kind == bridge_pkg::REQ_STORE_BLOCK) begin
            n_store = n_store + 1;
            for (int w = 0; w < 8; w++) begin
                ref_mem[{a[7:5], 3'(w)}] = blk[32*w +: 32];
            end
        end else begin
            n_load = n_load + 1;
        end
        // stray requests while the bridge is still launching
        repeat (2) begin
            @(posedge clk);
            r = $random(seed);
            req    <= r[0] ? bridge_pkg::REQ_STORE_BLOCK : bridge_pkg::REQ_LOAD_BLOCK;
            addr   <= {24'd0, r[15:8]};
            wblock <= random_block();
        end
        @(posedge clk);
        req <= bridge_pkg::REQ_NONE;
        wait_finish(seen);
        if (seen) begin
            if (kind == bridge_pkg::REQ_LOAD_BLOCK) begin
                compare_value("rblock", rblock, expected_block(a[7:5]));
            end
            @(negedge clk);
            compare_value("task_finish", 256'(task_finish), 256'd0);
        end
    endtask

    initial begin
        integer             r;
        bridge_pkg::addr_t  a;
        bridge_pkg::addr_t  prev_a;
        logic               last_store;
        bridge_pkg::req_e   kind;

        rstn   <= 1'b0;
        req    <= bridge_pkg::REQ_NONE;
        addr   <= '0;
        wblock <= '0;
        prev_a = '0;
        last_store = 1'b0;
        for (int i = 0; i < 64; i++) begin
            ref_mem[6'(i)] = 32'h9e3779b9 * 32'(i + 1);
        end
        repeat (2) @(posedge clk);
        rstn <= 1'b1;

        // quiet bus after reset
        @(negedge clk);
        compare_value("task_finish", 256'(task_finish), 256'd0);
        compare_value("arvalid", 256'(arvalid), 256'd0);
        compare_value("rready", 256'(rready), 256'd0);
        compare_value("awvalid", 256'(awvalid), 256'd0);
        compare_value("wvalid", 256'(wvalid), 256'd0);
        compare_value("wlast", 256'(wlast), 256'd0);
        compare_value("bready", 256'(bready), 256'd0);

        for (int n = 0; n < 200 && !timed_out; n++) begin
            r = $random(seed);
            a = {24'd0, r[15:8]};
            // often reread the block just stored
            if (last_store && r[1]) begin
                a[7:5] = prev_a[7:5];
            end
            kind = r[0] ? bridge_pkg::REQ_STORE_BLOCK : bridge_pkg::REQ_LOAD_BLOCK;
            run_request(kind, a, random_block());
            last_store = r[0];
            prev_a = a;
        end

        repeat (4) @(negedge clk);
        compare_value("slave faults", 256'(fault_count), 256'd0);
        compare_value("read bursts", 256'(ar_count), 256'(n_load));
        compare_value("write bursts", 256'(aw_count), 256'(n_store));
        compare_value("task_finish pulses", 256'(finish_count), 256'(n_load + n_store));
        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+hdl
hdl/bridge_pkg.sv
hdl/req_ctrl.sv
hdl/rd_burst.sv
hdl/wr_burst.sv
hdl/axi_block_bridge.sv
verification/axi_mem_slave.sv
verification/tb_axi_block_bridge.sv

/* run.sh */
#!/bin/sh
# build and run the block bridge regression with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_axi_block_bridge --Mdir "$OBJ" -f compile.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ/Vtb_axi_block_bridge" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
